//--- rtl/lsuPkg.sv
package lsuPkg;

    // Program-order tag compared by signed difference so it may wrap
    typedef logic [7:0] SqN;

    typedef logic [7:0] WordAddr;
    typedef logic [9:0] ByteAddr;
    typedef logic [31:0] DataWord;
    typedef logic [3:0] ByteMask;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } AccessSize;

    // Data is already placed in its byte lanes
    typedef struct packed {
        logic valid;
        SqN sqN;
        ByteAddr addr;
        DataWord data;
        ByteMask wmask;
    } StoreReq;

    typedef struct packed {
        logic valid;
        SqN sqN;
        ByteAddr addr;
        AccessSize size;
    } LoadReq;

    typedef struct packed {
        logic taken;
        SqN sqN;
    } BranchSquash;

    typedef struct packed {
        logic en;
        WordAddr addr;
        DataWord data;
        ByteMask wmask;
    } MemWrite;

endpackage

//--- rtl/storeQueue.sv
`timescale 1ns/10ps

module storeQueue #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  lsuPkg::StoreReq     stIn,
    input  lsuPkg::LoadReq      ldIn,
    input  lsuPkg::SqN          curSqN,
    input  lsuPkg::BranchSquash squash,
    input  logic                headGrant,
    output lsuPkg::MemWrite     headWrite,
    output lsuPkg::DataWord     fwdData,
    output lsuPkg::ByteMask     fwdMask,
    output logic                sqFull,
    output logic                sqEmpty
);

    localparam int CNT_WIDTH = $clog2(NUM_ENTRIES + 1);

    typedef struct packed {
        logic valid;
        logic ready;
        lsuPkg::SqN sqN;
        lsuPkg::WordAddr addr;
        lsuPkg::DataWord data;
        lsuPkg::ByteMask wmask;
    } SqEntry;

    // Entry 0 is the oldest store
    SqEntry entries [NUM_ENTRIES];
    SqEntry nxt [NUM_ENTRIES];
    logic [CNT_WIDTH-1:0] count;
    logic [CNT_WIDTH-1:0] tail;
    logic stAccept;

    // A store strobed together with a squash survives only if it is not younger
    assign stAccept = stIn.valid && !sqFull &&
        !(squash.taken && $signed(stIn.sqN - squash.sqN) > 0);

    always_comb begin
        nxt = entries;
        tail = count;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if ($signed(curSqN - nxt[i].sqN) > 0)
                nxt[i].ready = 1'b1;
        end

        if (headGrant) begin
            for (int i = 0; i < NUM_ENTRIES - 1; i++) begin
                nxt[i] = nxt[i + 1];
            end
            nxt[NUM_ENTRIES - 1].valid = 1'b0;
            tail = tail - 1'b1;
        end

        // Squashed stores are always the youngest, so the tail just moves back
        if (squash.taken) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (nxt[i].valid && !nxt[i].ready &&
                    $signed(nxt[i].sqN - squash.sqN) > 0) begin
                    nxt[i].valid = 1'b0;
                    tail = tail - 1'b1;
                end
            end
        end

        if (stAccept) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                if (i == tail) begin
                    nxt[i].valid = 1'b1;
                    nxt[i].ready = $signed(curSqN - stIn.sqN) > 0;
                    nxt[i].sqN = stIn.sqN;
                    nxt[i].addr = stIn.addr[9:2];
                    nxt[i].data = stIn.data;
                    nxt[i].wmask = stIn.wmask;
                end
            end
            tail = tail + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
            count <= '0;
            sqFull <= 1'b0;
            sqEmpty <= 1'b1;
        end else begin
            entries <= nxt;
            count <= tail;
            sqFull <= (tail == NUM_ENTRIES);
            sqEmpty <= (tail == 0);
        end
    end

    assign headWrite.en = entries[0].valid && entries[0].ready;
    assign headWrite.addr = entries[0].addr;
    assign headWrite.data = entries[0].data;
    assign headWrite.wmask = entries[0].wmask;

    // Forwarding lookup where later entries override earlier ones
    always_comb begin
        case (ldIn.size)
            lsuPkg::SIZE_BYTE: fwdMask = ~(4'b0001 << ldIn.addr[1:0]);
            lsuPkg::SIZE_HALF: fwdMask = ldIn.addr[1] ? 4'b0011 : 4'b1100;
            default: fwdMask = 4'b0000;
        endcase
        fwdData = '0;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entries[i].valid && entries[i].addr == ldIn.addr[9:2] &&
                ($signed(entries[i].sqN - ldIn.sqN) < 0 || entries[i].ready)) begin
                for (int b = 0; b < 4; b++) begin
                    if (entries[i].wmask[b]) begin
                        fwdData[8*b +: 8] = entries[i].data[8*b +: 8];
                        fwdMask[b] = 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- rtl/memArbiter.sv
`timescale 1ns/10ps

module memArbiter (
    input  lsuPkg::LoadReq  ldIn,
    input  lsuPkg::MemWrite headWrite,
    output logic            headGrant,
    output lsuPkg::WordAddr memAddr,
    output logic            memWe,
    output lsuPkg::DataWord memWdata,
    output lsuPkg::ByteMask memWmask
);

    logic ldPresent;

    // Loads always win the port
    assign ldPresent = ldIn.valid;
    assign headGrant = headWrite.en && !ldPresent;

    always_comb begin
        if (ldPresent) begin
            memAddr = ldIn.addr[9:2];
        end else begin
            memAddr = headWrite.addr;
        end
    end

    assign memWe = headGrant;
    assign memWdata = headWrite.data;
    assign memWmask = headGrant ? headWrite.wmask : 4'b0000;

endmodule

//--- rtl/dataMemory.sv
`timescale 1ns/10ps

module dataMemory #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic            clk,
    input  lsuPkg::WordAddr memAddr,
    input  logic            memWe,
    input  lsuPkg::DataWord memWdata,
    input  lsuPkg::ByteMask memWmask,
    output lsuPkg::DataWord rdData
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    lsuPkg::DataWord mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (memWe) begin
            for (int b = 0; b < 4; b++) begin
                if (memWmask[b])
                    mem[memAddr][8*b +: 8] <= memWdata[8*b +: 8];
            end
        end
        // Registered read forms the first load stage
        rdData <= mem[memAddr];
    end

endmodule

//--- rtl/loadUnit.sv
`timescale 1ns/10ps

module loadUnit (
    input  logic            clk,
    input  logic            rst,
    input  lsuPkg::LoadReq  ldIn,
    input  lsuPkg::DataWord fwdData,
    input  lsuPkg::ByteMask fwdMask,
    input  lsuPkg::DataWord rdData,
    output logic            ldDone,
    output lsuPkg::DataWord ldData
);

    logic s1Valid;
    logic [1:0] s1Off;
    lsuPkg::AccessSize s1Size;
    lsuPkg::DataWord s1FwdData;
    lsuPkg::ByteMask s1FwdMask;
    lsuPkg::DataWord merged;
    lsuPkg::DataWord shifted;
    lsuPkg::DataWord result;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            ldDone <= 1'b0;
        end else begin
            s1Valid <= ldIn.valid;
            ldDone <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Off <= ldIn.addr[1:0];
        s1Size <= ldIn.size;
        s1FwdData <= fwdData;
        s1FwdMask <= fwdMask;
        ldData <= result;
    end

    // Queue bytes win over memory bytes
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = s1FwdMask[b] ? s1FwdData[8*b +: 8] : rdData[8*b +: 8];
        end
        shifted = merged >> {s1Off, 3'b000};
        case (s1Size)
            lsuPkg::SIZE_BYTE: result = {24'b0, shifted[7:0]};
            lsuPkg::SIZE_HALF: result = {16'b0, shifted[15:0]};
            default: result = shifted;
        endcase
    end

endmodule

//--- rtl/lsuTop.sv
`timescale 1ns/10ps

module lsuTop #(
    parameter int NUM_ENTRIES = 8,
    parameter int ADDR_WIDTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  lsuPkg::StoreReq     stIn,
    input  lsuPkg::LoadReq      ldIn,
    input  lsuPkg::SqN          curSqN,
    input  lsuPkg::BranchSquash squash,
    output logic                sqFull,
    output logic                sqEmpty,
    output logic                ldDone,
    output lsuPkg::DataWord     ldData
);

    lsuPkg::MemWrite headWrite;
    logic headGrant;
    lsuPkg::WordAddr memAddr;
    logic memWe;
    lsuPkg::DataWord memWdata;
    lsuPkg::ByteMask memWmask;
    lsuPkg::DataWord rdData;
    lsuPkg::DataWord fwdData;
    lsuPkg::ByteMask fwdMask;

    storeQueue #(.NUM_ENTRIES(NUM_ENTRIES)) sq (
        .clk(clk), .rst(rst), .stIn(stIn), .ldIn(ldIn), .curSqN(curSqN),
        .squash(squash), .headGrant(headGrant), .headWrite(headWrite),
        .fwdData(fwdData), .fwdMask(fwdMask), .sqFull(sqFull), .sqEmpty(sqEmpty)
    );

    memArbiter arb (
        .ldIn(ldIn), .headWrite(headWrite), .headGrant(headGrant), .memAddr(memAddr),
        .memWe(memWe), .memWdata(memWdata), .memWmask(memWmask)
    );

    dataMemory #(.ADDR_WIDTH(ADDR_WIDTH)) dmem (
        .clk(clk), .memAddr(memAddr), .memWe(memWe), .memWdata(memWdata),
        .memWmask(memWmask), .rdData(rdData)
    );

    loadUnit lu (
        .clk(clk), .rst(rst), .ldIn(ldIn), .fwdData(fwdData), .fwdMask(fwdMask),
        .rdData(rdData), .ldDone(ldDone), .ldData(ldData)
    );

endmodule

//--- test/lsuModel.svh
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

typedef struct packed {
    lsuPkg::SqN sqN;
    lsuPkg::WordAddr addr;
    lsuPkg::DataWord data;
    lsuPkg::ByteMask mask;
} PendStore;

// Memory image holding committed stores only
lsuPkg::DataWord image [256];
// Uncommitted stores, oldest first
PendStore pending [$];

function automatic lsuPkg::DataWord overlay(lsuPkg::DataWord base, PendStore st);
    for (int b = 0; b < 4; b++) begin
        if (st.mask[b])
            base[8*b +: 8] = st.data[8*b +: 8];
    end
    return base;
endfunction

function automatic lsuPkg::DataWord expectedLoad(lsuPkg::ByteAddr addr,
                                                 lsuPkg::AccessSize size);
    lsuPkg::DataWord word;
    word = image[addr[9:2]];
    foreach (pending[i]) begin
        if (pending[i].addr == addr[9:2])
            word = overlay(word, pending[i]);
    end
    word = word >> (8 * addr[1:0]);
    case (size)
        lsuPkg::SIZE_BYTE: return word & 32'h0000_00ff;
        lsuPkg::SIZE_HALF: return word & 32'h0000_ffff;
        default: return word;
    endcase
endfunction

task automatic modelCommit(lsuPkg::SqN cur);
    while (pending.size() > 0 && $signed(pending[0].sqN - cur) < 0) begin
        image[pending[0].addr] = overlay(image[pending[0].addr], pending[0]);
        void'(pending.pop_front());
    end
endtask

// Squashed stores are always the youngest ones
task automatic modelSquash(lsuPkg::SqN sq);
    while (pending.size() > 0 && $signed(pending[$].sqN - sq) > 0)
        void'(pending.pop_back());
endtask

`endif

//--- test/lsuTb.sv
`timescale 1ns/10ps

module lsuTb;

    localparam int NUM_ENTRIES = 8;
    localparam int NUM_OPS = 400;
    // Random phase budget plus room for the directed phases and drains
    localparam int WATCHDOG_NS = NUM_OPS * 4 * 20 + 2000;

    typedef struct packed {
        int issueCycle;
        lsuPkg::DataWord data;
    } ExpLoad;

    logic clk;
    logic rst;
    lsuPkg::StoreReq stIn;
    lsuPkg::LoadReq ldIn;
    lsuPkg::SqN curSqN;
    lsuPkg::BranchSquash squash;
    logic sqFull;
    logic sqEmpty;
    logic ldDone;
    lsuPkg::DataWord ldData;

    integer seed;
    int cycle;
    lsuPkg::SqN nextSqN;
    logic [15:0] touched;
    ExpLoad expLoads [$];

    `include "lsuModel.svh"

    lsuTop #(.NUM_ENTRIES(NUM_ENTRIES), .ADDR_WIDTH(8)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $fatal(1, "Timeout");
    end

    task automatic checkValue(string name, lsuPkg::DataWord actual, lsuPkg::DataWord expected);
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    function automatic int randomBelow(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic lsuPkg::ByteAddr randomAddr(lsuPkg::AccessSize size, int words);
        int off;
        case (size)
            lsuPkg::SIZE_BYTE: off = randomBelow(4);
            lsuPkg::SIZE_HALF: off = 2 * randomBelow(2);
            default: off = 0;
        endcase
        return lsuPkg::ByteAddr'(randomBelow(words) * 4 + off);
    endfunction

    // Checks the load result due this cycle, then clears the strobes
    task automatic nextCycle();
        @(posedge clk);
        cycle++;
        #1;
        if (expLoads.size() > 0 && expLoads[0].issueCycle + 2 == cycle) begin
            checkValue("ldDone", ldDone, 1);
            checkValue("ldData", ldData, expLoads[0].data);
            void'(expLoads.pop_front());
        end else begin
            checkValue("ldDone", ldDone, 0);
        end
        stIn = '0;
        ldIn = '0;
        squash = '0;
    endtask

    task automatic issueLoad(lsuPkg::ByteAddr addr, lsuPkg::AccessSize size);
        ldIn = '{valid: 1'b1, sqN: nextSqN, addr: addr, size: size};
        expLoads.push_back('{issueCycle: cycle, data: expectedLoad(addr, size)});
        nextSqN++;
    endtask

    task automatic issueStore(lsuPkg::ByteAddr addr, lsuPkg::AccessSize size,
                              lsuPkg::DataWord raw);
        lsuPkg::ByteMask mask;
        lsuPkg::DataWord data;
        case (size)
            lsuPkg::SIZE_BYTE: mask = 4'b0001 << addr[1:0];
            lsuPkg::SIZE_HALF: mask = 4'b0011 << addr[1:0];
            default: mask = 4'b1111;
        endcase
        data = raw << (8 * addr[1:0]);
        stIn = '{valid: 1'b1, sqN: nextSqN, addr: addr, data: data, wmask: mask};
        pending.push_back('{sqN: nextSqN, addr: addr[9:2], data: data, mask: mask});
        touched[addr[5:2]] = 1'b1;
        nextSqN++;
    endtask

    task automatic randomLoad(int words);
        lsuPkg::AccessSize size;
        size = lsuPkg::AccessSize'(randomBelow(3));
        issueLoad(randomAddr(size, words), size);
    endtask

    task automatic randomStore(int words);
        lsuPkg::AccessSize size;
        size = lsuPkg::AccessSize'(randomBelow(3));
        issueStore(randomAddr(size, words), size, $random(seed));
    endtask

    task automatic commitTo(lsuPkg::SqN newCur);
        curSqN = newCur;
        modelCommit(newCur);
    endtask

    task automatic waitEmpty();
        while (!sqEmpty)
            nextCycle();
    endtask

    // Every size at every aligned offset of each touched word
    task automatic verifyImage();
        for (int w = 0; w < 16; w++) begin
            if (touched[w]) begin
                for (int off = 0; off < 4; off++) begin
                    nextCycle();
                    issueLoad(lsuPkg::ByteAddr'(w * 4 + off), lsuPkg::SIZE_BYTE);
                end
                for (int off = 0; off < 4; off += 2) begin
                    nextCycle();
                    issueLoad(lsuPkg::ByteAddr'(w * 4 + off), lsuPkg::SIZE_HALF);
                end
                nextCycle();
                issueLoad(lsuPkg::ByteAddr'(w * 4), lsuPkg::SIZE_WORD);
            end
        end
    endtask

    task automatic randomCycle();
        int span;
        lsuPkg::SqN sq;
        nextCycle();
        span = int'(lsuPkg::SqN'(nextSqN - curSqN));
        if (randomBelow(10) == 0) begin
            sq = lsuPkg::SqN'(curSqN + randomBelow(span + 1) - 1);
            // A store in the squash cycle is younger, so it gets dropped
            if (!sqFull && randomBelow(2) == 1)
                randomStore(16);
            squash = '{taken: 1'b1, sqN: sq};
            modelSquash(sq);
        end else begin
            if (randomBelow(2) == 1)
                randomLoad(16);
            if (!sqFull && randomBelow(2) == 1)
                randomStore(16);
            if (span > 0 && (span > 24 || randomBelow(3) == 0))
                commitTo(lsuPkg::SqN'(curSqN + 1 + randomBelow(span)));
        end
    endtask

    initial begin
        seed = 10559;
        cycle = 0;
        nextSqN = '0;
        touched = '0;
        rst = 1'b1;
        stIn = '0;
        ldIn = '0;
        curSqN = '0;
        squash = '0;
        foreach (image[i])
            image[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        checkValue("sqEmpty", sqEmpty, 1);
        checkValue("sqFull", sqFull, 0);
        checkValue("ldDone", ldDone, 0);

        // Fill with uncommitted stores to four words that the loads then see by forwarding
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            nextCycle();
            randomStore(4);
        end
        nextCycle();
        checkValue("sqFull", sqFull, 1);
        for (int w = 0; w < 4; w++) begin
            nextCycle();
            issueLoad(lsuPkg::ByteAddr'(w * 4), lsuPkg::SIZE_WORD);
        end
        nextCycle();
        commitTo(nextSqN);
        waitEmpty();
        verifyImage();

        for (int i = 0; i < NUM_OPS; i++)
            randomCycle();

        // Back-to-back loads keep ready stores from draining
        for (int i = 0; i < 4; i++) begin
            nextCycle();
            randomLoad(16);
            if (!sqFull)
                randomStore(16);
        end
        nextCycle();
        randomLoad(16);
        commitTo(nextSqN);
        for (int i = 0; i < 20; i++) begin
            nextCycle();
            checkValue("sqEmpty", sqEmpty, 0);
            randomLoad(16);
        end
        waitEmpty();
        verifyImage();
        while (expLoads.size() > 0)
            nextCycle();
        nextCycle();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+test
rtl/lsuPkg.sv
rtl/storeQueue.sv
rtl/memArbiter.sv
rtl/dataMemory.sv
rtl/loadUnit.sv
rtl/lsuTop.sv
test/lsuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module lsuTb -f flist.f -Mdir obj_dir -o lsuSim

./obj_dir/lsuSim > sim.log 2>&1 || true
cat sim.log

grep -qx "TESTS PASSED" sim.log
